// File: hb_control.f
hw/hb_pkg.sv
hw/adc_frontend.sv
hw/startup_seq.sv
hw/tank_switching.sv
hw/dead_time.sv
hw/gate_driver.sv
hw/hb_control_top.sv
bench/hb_control_assertions.sv
bench/hb_control_tb.sv

// File: Makefile
TOP := hb_control_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f hb_control.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f hb_control.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Verification passed"

clean:
	rm -rf obj_dir

// File: bench/hb_control_tb.sv
`timescale 1ns/1ps

module hb_control_tb;

   import hb_pkg::*;

   // ============================================================
   // constants and signals
   // ============================================================

   localparam int MAX_ROWS        = 12;
   localparam int DISABLED_CYCLES = 8;
   localparam int STARTUP_CYCLES  = int'(CHARGE_END) + 5;
   localparam int MARGIN          = 64;
   // both low sides, then q1 with q4
   localparam gate_t PAT_BOOT   = 4'b1100;
   localparam gate_t PAT_CHARGE = 4'b1001;

   logic        ADA_DCO = 1'b0;
   logic        i_rst_n;
   adc_sample_t i_ada_data;
   logic        i_ada_or;
   logic        i_enable;
   angle_t      i_phi;
   dt_sel_t     i_dt_sel;
   gate_t       o_q;
   logic        o_adc_over_range;
   logic        o_converter_on;

   // stimulus table columns
   string       row_name [MAX_ROWS];
   dt_sel_t     row_dt_sel [MAX_ROWS];
   angle_t      row_phi [MAX_ROWS];
   int          row_half [MAX_ROWS];
   logic        row_ovr [MAX_ROWS];
   logic        row_neg [MAX_ROWS];
   adc_sample_t row_raw [MAX_ROWS];
   logic        row_lvl [MAX_ROWS];
   // leg 1 off, leg 1 on, leg 2 off, leg 2 on, cycles after the drive edge
   int          row_dly [MAX_ROWS][4];
   int          row_count = 0;

   logic [31:0] rng_state;
   // settled leg 1 level
   logic        cur_lvl;
   int          cycle_count = 0;
   int          cycle_limit = 0;

   hb_control_top dut_i (
      .ADA_DCO          (ADA_DCO),
      .i_rst_n          (i_rst_n),
      .i_ada_data       (i_ada_data),
      .i_ada_or         (i_ada_or),
      .i_enable         (i_enable),
      .i_phi            (i_phi),
      .i_dt_sel         (i_dt_sel),
      .o_q              (o_q),
      .o_adc_over_range (o_adc_over_range),
      .o_converter_on   (o_converter_on)
   );

   always #5 ADA_DCO = ~ADA_DCO;

   // run length guard
   always @(posedge ADA_DCO) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count > cycle_limit) begin
         $display("Timeout, the tests did not finish within %0d cycles", cycle_limit);
         $display("Verification failed");
         $fatal(1, "cycle limit reached");
      end
   end

   // ============================================================
   // helpers
   // ============================================================

   task automatic compare_value(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
      if (expected !== actual) begin
         $display("FAILED %s expected 0x%0h actual 0x%0h", name, expected, actual);
         $display("Verification failed");
         $fatal(1, "mismatch in %s", name);
      end
   endtask

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // random magnitude 1 to 8191 with the given raw sign
   task automatic random_raw(input logic neg, output adc_sample_t raw);
      int mag;
      rng_state = xorshift32(rng_state);
      mag = int'(rng_state % 32'd8191) + 1;
      raw = neg ? adc_sample_t'(-mag) : adc_sample_t'(mag);
   endtask

   task automatic add_row(input string name, input dt_sel_t dt_sel, input angle_t phi,
                          input int half, input logic ovr, input logic neg,
                          input adc_sample_t raw, input logic lvl, input int d1_off,
                          input int d1_on, input int d2_off, input int d2_on);
      row_name[row_count]   = name;
      row_dt_sel[row_count] = dt_sel;
      row_phi[row_count]    = phi;
      row_half[row_count]   = half;
      row_ovr[row_count]    = ovr;
      row_neg[row_count]    = neg;
      row_raw[row_count]    = raw;
      row_lvl[row_count]    = lvl;
      row_dly[row_count]    = '{d1_off, d1_on, d2_off, d2_on};
      row_count             = row_count + 1;
   endtask

   // leg 1 and leg 2 both at lvl
   function automatic gate_t steady_gates(input logic lvl);
      return lvl ? 4'b0011 : 4'b1100;
   endfunction

   // leaving side drops first, arriving side waits out the dead time
   function automatic gate_t transition_gates(input logic lvl, input int t, input int r);
      logic  leg1_off;
      logic  leg1_on;
      logic  leg2_off;
      logic  leg2_on;
      gate_t g;
      leg1_off  = (t >= row_dly[r][0]);
      leg1_on   = (t >= row_dly[r][1]);
      leg2_off  = (t >= row_dly[r][2]);
      leg2_on   = (t >= row_dly[r][3]);
      g         = '0;
      g[Q1_BIT] = lvl ? leg1_on : !leg1_off;
      g[Q3_BIT] = lvl ? !leg1_off : leg1_on;
      g[Q2_BIT] = lvl ? leg2_on : !leg2_off;
      g[Q4_BIT] = lvl ? !leg2_off : leg2_on;
      return g;
   endfunction

   // one half period of the tank sign, checked every cycle at the falling edge
   task automatic run_half(input int r, input string part, input adc_sample_t raw,
                           input logic ovr, input logic lvl);
      gate_t exp_q;
      logic  moving;
      string name;
      moving = (lvl != cur_lvl);
      @(posedge ADA_DCO);
      i_ada_data <= raw;
      i_ada_or   <= ovr;
      for (int t = 1; t < row_half[r]; t++) begin
         @(posedge ADA_DCO);
         @(negedge ADA_DCO);
         name  = $sformatf("%s %s t=%0d", row_name[r], part, t);
         exp_q = moving ? transition_gates(lvl, t, r) : steady_gates(lvl);
         compare_value({name, " o_q"}, 32'(exp_q), 32'(o_q));
         compare_value({name, " over_range"}, 32'(ovr), 32'(o_adc_over_range));
         compare_value({name, " converter_on"}, 32'd1, 32'(o_converter_on));
      end
      cur_lvl = lvl;
   endtask

   // phase follows enable by one edge, the driver adds one more
   task automatic startup_sequence(input string test);
      gate_t exp_q;
      logic  exp_on;
      string name;
      @(posedge ADA_DCO);
      i_enable <= 1'b1;
      for (int t = 1; t < STARTUP_CYCLES; t++) begin
         @(posedge ADA_DCO);
         @(negedge ADA_DCO);
         if (t < 2) begin
            exp_q = '0;
         end else if (t <= int'(BOOT_END) + 2) begin
            exp_q = PAT_BOOT;
         end else if (t <= int'(CHARGE_END) + 2) begin
            exp_q = PAT_CHARGE;
         end else begin
            exp_q = steady_gates(cur_lvl);
         end
         exp_on = (t >= int'(CHARGE_END) + 2);
         name   = $sformatf("%s t=%0d", test, t);
         compare_value({name, " o_q"}, 32'(exp_q), 32'(o_q));
         compare_value({name, " converter_on"}, 32'(exp_on), 32'(o_converter_on));
      end
   endtask

   task automatic disable_bridge(input string test);
      string name;
      @(posedge ADA_DCO);
      i_enable <= 1'b0;
      for (int t = 1; t <= DISABLED_CYCLES; t++) begin
         @(posedge ADA_DCO);
         @(negedge ADA_DCO);
         name = $sformatf("%s t=%0d", test, t);
         // gates may take two cycles to clear
         if (t >= 2) begin
            compare_value({name, " o_q"}, 32'd0, 32'(o_q));
         end
         compare_value({name, " converter_on"}, 32'd0, 32'(o_converter_on));
         compare_value({name, " over_range"}, 32'd0, 32'(o_adc_over_range));
      end
   endtask

   // ============================================================
   // stimulus table and main sequence
   // ============================================================

   task automatic load_table();
      //      name          sel   phi     half ovr   neg   raw        lvl  delays
      add_row("dt_sel0",     2'd0, 8'd10,  40, 1'b0, 1'b1, 14'sh0000, 1'b1, 4, 12, 15, 23);
      add_row("dt_sel1",     2'd1, 8'd10,  40, 1'b0, 1'b0, 14'sh0000, 1'b0, 4, 6, 15, 17);
      add_row("dt_sel2",     2'd2, 8'd10,  40, 1'b0, 1'b1, 14'sh0000, 1'b1, 4, 8, 15, 19);
      add_row("dt_sel3",     2'd3, 8'd10,  40, 1'b0, 1'b0, 14'sh0000, 1'b0, 4, 10, 15, 21);
      add_row("or_neg_full", 2'd1, 8'd0,   30, 1'b1, 1'b0, 14'sh2000, 1'b1, 4, 6, 5, 7);
      add_row("or_other",    2'd1, 8'd0,   30, 1'b1, 1'b0, 14'sh3F00, 1'b0, 4, 6, 5, 7);
      add_row("phi_45",      2'd2, 8'd45,  60, 1'b0, 1'b1, 14'sh0000, 1'b1, 4, 8, 50, 54);
      add_row("phi_sat",     2'd0, 8'd200, 110, 1'b0, 1'b0, 14'sh0000, 1'b0, 4, 12, 95, 103);
      add_row("phi_max",     2'd3, 8'd90,  110, 1'b0, 1'b1, 14'sh0000, 1'b1, 4, 10, 95, 101);
      add_row("phi_zero",    2'd1, 8'd0,   20, 1'b0, 1'b0, 14'sh0000, 1'b0, 4, 6, 5, 7);
   endtask

   initial begin
      adc_sample_t raw;
      i_rst_n    <= 1'b0;
      i_ada_data <= '0;
      i_ada_or   <= 1'b0;
      i_enable   <= 1'b0;
      i_phi      <= '0;
      i_dt_sel   <= 2'd1;
      rng_state = 32'h0678_9181;
      // a zero sample reads as not negative
      cur_lvl = 1'b1;
      load_table();
      cycle_limit = 2 + 2 * (DISABLED_CYCLES + 1 + STARTUP_CYCLES) + MARGIN;
      for (int r = 0; r < row_count; r++) begin
         cycle_limit = cycle_limit + 3 * row_half[r] + 1;
      end
      repeat (2) @(posedge ADA_DCO);
      i_rst_n <= 1'b1;
      disable_bridge("reset_disabled");
      startup_sequence("startup");
      // lead half settles the opposite sign, then the edge under test and back
      for (int r = 0; r < row_count; r++) begin
         @(posedge ADA_DCO);
         i_dt_sel <= row_dt_sel[r];
         i_phi    <= row_phi[r];
         random_raw(!row_lvl[r], raw);
         run_half(r, "lead", raw, 1'b0, !row_lvl[r]);
         if (row_ovr[r]) begin
            raw = row_raw[r];
         end else begin
            random_raw(row_neg[r], raw);
         end
         run_half(r, "edge", raw, row_ovr[r], row_lvl[r]);
         random_raw(!row_lvl[r], raw);
         run_half(r, "return", raw, 1'b0, !row_lvl[r]);
      end
      disable_bridge("restart_off");
      startup_sequence("restart");
      $display("Verification passed");
      $finish;
   end

endmodule

// File: bench/hb_control_assertions.sv
`timescale 1ns/1ps

module hb_control_assertions (
   input logic          ADA_DCO,
   input logic          i_rst_n,
   input logic          i_enable,
   // registered gate outputs of the driver
   input hb_pkg::gate_t i_q
);

   import hb_pkg::*;

   // leg 1 high and low side never together
   a_leg1_no_short : assert property (@(posedge ADA_DCO) disable iff (!i_rst_n)
      !(i_q[Q1_BIT] && i_q[Q3_BIT]))
      else $error("q1 and q3 on in the same cycle");

   // same for leg 2
   a_leg2_no_short : assert property (@(posedge ADA_DCO) disable iff (!i_rst_n)
      !(i_q[Q2_BIT] && i_q[Q4_BIT]))
      else $error("q2 and q4 on in the same cycle");

   // gates off one register after a low enable
   a_off_when_disabled : assert property (@(posedge ADA_DCO) disable iff (!i_rst_n)
      !i_enable |=> (i_q == '0))
      else $error("gates still on after the enable dropped");

endmodule

bind gate_driver hb_control_assertions u_gate_assertions (
   .ADA_DCO  (ADA_DCO),
   .i_rst_n  (i_rst_n),
   .i_enable (i_enable),
   .i_q      (o_q)
);

// File: hw/hb_control_top.sv
`timescale 1ns/1ps

module hb_control_top (
   // adc data clock, clocks the whole core
   input  logic                ADA_DCO,
   input  logic                i_rst_n,
   // tank adc
   input  hb_pkg::adc_sample_t i_ada_data,
   input  logic                i_ada_or,
   // converter enable level
   input  logic                i_enable,
   // leg 2 phase shift in cycles
   input  hb_pkg::angle_t      i_phi,
   // dead time select
   input  hb_pkg::dt_sel_t     i_dt_sel,
   // mosfet gates q1 to q4
   output hb_pkg::gate_t       o_q,
   output logic                o_adc_over_range,
   output logic                o_converter_on
);

   import hb_pkg::*;

   adc_sample_t    sample;
   startup_phase_t phase;
   gate_t          cmd;
   gate_t          gates_dt;

   // ============================================================
   // sensing and start-up
   // ============================================================

   adc_frontend u_adc_frontend (
      .ADA_DCO      (ADA_DCO),
      .i_rst_n      (i_rst_n),
      .i_ada_data   (i_ada_data),
      .i_ada_or     (i_ada_or),
      .o_sample     (sample),
      .o_over_range (o_adc_over_range)
   );

   startup_seq u_startup_seq (
      .ADA_DCO        (ADA_DCO),
      .i_rst_n        (i_rst_n),
      .i_enable       (i_enable),
      .o_phase        (phase),
      .o_converter_on (o_converter_on)
   );

   // ============================================================
   // switching path
   // ============================================================

   tank_switching u_tank_switching (
      .ADA_DCO  (ADA_DCO),
      .i_rst_n  (i_rst_n),
      .i_sample (sample),
      .i_phi    (i_phi),
      .o_cmd    (cmd)
   );

   dead_time u_dead_time (
      .ADA_DCO  (ADA_DCO),
      .i_rst_n  (i_rst_n),
      .i_cmd    (cmd),
      .i_dt_sel (i_dt_sel),
      .o_gates  (gates_dt)
   );

   // final gate stage with start-up patterns
   gate_driver u_gate_driver (
      .ADA_DCO  (ADA_DCO),
      .i_rst_n  (i_rst_n),
      .i_enable (i_enable),
      .i_phase  (phase),
      .i_gates  (gates_dt),
      .o_q      (o_q)
   );

endmodule

// File: hw/gate_driver.sv
`timescale 1ns/1ps

module gate_driver (
   input  logic                   ADA_DCO,
   input  logic                   i_rst_n,
   // enable level, gates off when low
   input  logic                   i_enable,
   // current start-up phase
   input  hb_pkg::startup_phase_t i_phase,
   // dead-timed run gates
   input  hb_pkg::gate_t          i_gates,
   // mosfet gate outputs
   output hb_pkg::gate_t          o_q
);

   import hb_pkg::*;

   gate_t pattern;
   logic  leg1_short;
   logic  leg2_short;

   // gate pattern per start-up phase
   always_comb begin
      pattern = '0;
      if (i_enable) begin
         case (i_phase)
            PH_BOOT:   pattern = GATES_BOOT;
            PH_CHARGE: pattern = GATES_CHARGE;
            PH_RUN:    pattern = i_gates;
            default:   pattern = '0;
         endcase
      end
   end

   // ============================================================
   // shoot-through block
   // ============================================================

   // high and low side of one leg on together
   assign leg1_short = pattern[Q1_BIT] & pattern[Q3_BIT];
   assign leg2_short = pattern[Q2_BIT] & pattern[Q4_BIT];

   // registered gate outputs
   always_ff @(posedge ADA_DCO) begin
      if (!i_rst_n) begin
         o_q <= '0;
      end else if (leg1_short || leg2_short) begin
         // all off on any short
         o_q <= '0;
      end else begin
         o_q <= pattern;
      end
   end

endmodule

// File: hw/dead_time.sv
`timescale 1ns/1ps

module dead_time (
   input  logic            ADA_DCO,
   input  logic            i_rst_n,
   // gate command from the switching logic
   input  hb_pkg::gate_t   i_cmd,
   // dead time select
   input  hb_pkg::dt_sel_t i_dt_sel,
   // gates with delayed turn-on
   output hb_pkg::gate_t   o_gates
);

   import hb_pkg::*;

   // selected dead time in cycles
   dt_cnt_t dt_len;

   // one turn-on counter per gate
   dt_cnt_t on_cnt_q [4];

   assign dt_len = DEADTIME_TABLE[i_dt_sel];

   // ============================================================
   // per gate delay
   // ============================================================

   always_ff @(posedge ADA_DCO) begin
      if (!i_rst_n) begin
         o_gates <= '0;
         for (int i = 0; i < 4; i++) begin
            on_cnt_q[i] <= '0;
         end
      end else begin
         for (int i = 0; i < 4; i++) begin
            if (!i_cmd[i]) begin
               // turn-off passes at once
               o_gates[i]  <= 1'b0;
               on_cnt_q[i] <= '0;
            end else if (on_cnt_q[i] >= dt_len) begin
               // command held high for the whole dead time
               o_gates[i] <= 1'b1;
            end else begin
               // still inside the dead time
               on_cnt_q[i] <= on_cnt_q[i] + 8'd1;
            end
         end
      end
   end

endmodule

// File: hw/tank_switching.sv
`timescale 1ns/1ps

module tank_switching (
   input  logic                ADA_DCO,
   input  logic                i_rst_n,
   // conditioned tank sample
   input  hb_pkg::adc_sample_t i_sample,
   // phase shift of leg 2 in cycles
   input  hb_pkg::angle_t      i_phi,
   // four-gate command before dead time
   output hb_pkg::gate_t       o_cmd
);

   import hb_pkg::*;

   // ============================================================
   // leg 1 from the tank sign
   // ============================================================

   logic leg1_q;
   logic leg1_d;
   logic leg1_change;

   // high while the sample is not negative
   assign leg1_d      = ~i_sample[ADC_W-1];
   assign leg1_change = (leg1_d != leg1_q);

   always_ff @(posedge ADA_DCO) begin
      if (!i_rst_n) begin
         leg1_q <= 1'b0;
      end else begin
         leg1_q <= leg1_d;
      end
   end

   // ============================================================
   // leg 2 phase shift
   // ============================================================

   angle_t phi_sat;
   angle_t dly_cnt_q;
   logic   leg2_q;
   logic   pending;

   // angles above the limit act as the limit
   assign phi_sat = (i_phi > PHI_MAX) ? PHI_MAX : i_phi;

   // leg 2 still has to catch up with leg 1
   assign pending = (leg2_q != leg1_q);

   always_ff @(posedge ADA_DCO) begin
      if (!i_rst_n) begin
         dly_cnt_q <= '0;
         leg2_q    <= 1'b0;
      end else begin
         if (leg1_change) begin
            // new edge on leg 1, restart the delay
            dly_cnt_q <= '0;
         end else if (pending && (dly_cnt_q < phi_sat)) begin
            dly_cnt_q <= dly_cnt_q + 8'd1;
         end
         // copy leg 1 once the delay has run out
         // >= covers an angle lowered during the delay
         if (pending && !leg1_change && (dly_cnt_q >= phi_sat)) begin
            leg2_q <= leg1_q;
         end
      end
   end

   // ============================================================
   // gate command
   // ============================================================

   // complementary pair per leg
   always_comb begin
      o_cmd         = '0;
      o_cmd[Q1_BIT] = leg1_q;
      o_cmd[Q3_BIT] = ~leg1_q;
      o_cmd[Q2_BIT] = leg2_q;
      o_cmd[Q4_BIT] = ~leg2_q;
   end

endmodule

// File: hw/startup_seq.sv
`timescale 1ns/1ps

module startup_seq (
   input  logic                   ADA_DCO,
   input  logic                   i_rst_n,
   // enable level, low forces the bridge off
   input  logic                   i_enable,
   output hb_pkg::startup_phase_t o_phase,
   // converter running
   output logic                   o_converter_on
);

   import hb_pkg::*;

   // ============================================================
   // start-up counter
   // ============================================================

   startup_cnt_t cnt_q;
   startup_phase_t phase_d;

   // counts while enabled, holds once past the precharge window
   always_ff @(posedge ADA_DCO) begin
      if (!i_rst_n) begin
         cnt_q <= '0;
      end else if (!i_enable) begin
         cnt_q <= '0;
      end else if (cnt_q <= CHARGE_END) begin
         cnt_q <= cnt_q + 8'd1;
      end
   end

   // ============================================================
   // phase state machine
   // ============================================================

   // next phase from the current count
   always_comb begin
      if (!i_enable) begin
         phase_d = PH_OFF;
      end else if (cnt_q <= BOOT_END) begin
         // low sides on, bootstrap caps charging
         phase_d = PH_BOOT;
      end else if (cnt_q <= CHARGE_END) begin
         // tank precharge
         phase_d = PH_CHARGE;
      end else begin
         phase_d = PH_RUN;
      end
   end

   // phase register, first boot cycle one edge after enable
   always_ff @(posedge ADA_DCO) begin
      if (!i_rst_n) begin
         o_phase <= PH_OFF;
      end else begin
         o_phase <= phase_d;
      end
   end

   // run indicator
   assign o_converter_on = (o_phase == PH_RUN);

endmodule

// File: hw/adc_frontend.sv
`timescale 1ns/1ps

module adc_frontend (
   input  logic                ADA_DCO,
   input  logic                i_rst_n,
   // raw tank sample, two's complement
   input  hb_pkg::adc_sample_t i_ada_data,
   // over-range flag from the adc
   input  logic                i_ada_or,
   output hb_pkg::adc_sample_t o_sample,
   output logic                o_over_range
);

   import hb_pkg::*;

   // next conditioned sample
   adc_sample_t sample_d;

   // clamp on over-range, otherwise undo the inverted sensing polarity
   always_comb begin
      if (i_ada_or) begin
         // raw negative full scale means the tank is past positive full scale
         if (i_ada_data == ADC_NEG_FULL) begin
            sample_d = ADC_POS_FULL;
         end else begin
            sample_d = ADC_NEG_FULL;
         end
      end else begin
         sample_d = -i_ada_data;
      end
   end

   // one register stage on the adc data clock
   always_ff @(posedge ADA_DCO) begin
      if (!i_rst_n) begin
         o_sample     <= '0;
         o_over_range <= 1'b0;
      end else begin
         o_sample     <= sample_d;
         // flag for the over-range indicator
         o_over_range <= i_ada_or;
      end
   end

endmodule

// File: hw/hb_pkg.sv
package hb_pkg;

   // ============================================================
   // tank adc
   // ============================================================

   localparam int ADC_W = 14;

   // signed two's complement sample from the tank adc
   typedef logic signed [ADC_W-1:0] adc_sample_t;

   // clamp levels used under over-range
   localparam adc_sample_t ADC_POS_FULL = 14'sh1FFF;
   localparam adc_sample_t ADC_NEG_FULL = 14'sh2000;

   // ============================================================
   // gates and switching
   // ============================================================

   // one bit per mosfet gate
   typedef logic [3:0] gate_t;

   // leg 1 high and low side
   localparam int Q1_BIT = 0;
   localparam int Q3_BIT = 2;
   // leg 2 high and low side
   localparam int Q2_BIT = 1;
   localparam int Q4_BIT = 3;

   // phase shift of leg 2 in clock cycles
   typedef logic [7:0] angle_t;
   localparam angle_t PHI_MAX = 8'd90;

   // dead time select and counter
   typedef logic [1:0] dt_sel_t;
   typedef logic [7:0] dt_cnt_t;

   // dead time in cycles per select value
   localparam dt_cnt_t DEADTIME_TABLE [4] = '{8'd8, 8'd2, 8'd4, 8'd6};

   // ============================================================
   // start-up sequence
   // ============================================================

   typedef logic [7:0] startup_cnt_t;

   // last count of bootstrap charging
   localparam startup_cnt_t BOOT_END = 8'd10;
   // last count of tank precharge
   localparam startup_cnt_t CHARGE_END = 8'd14;

   // both low sides on to charge the bootstrap caps
   localparam gate_t GATES_BOOT = 4'b1100;
   // q1 and q4 on to precharge the tank
   localparam gate_t GATES_CHARGE = 4'b1001;

   typedef enum logic [1:0] {
      PH_OFF,
      PH_BOOT,
      PH_CHARGE,
      PH_RUN
   } startup_phase_t;

endpackage
